//--- serdes_pkg.sv
/*
 * serializer test stream definitions
 * frame layout, pattern memory sizes, generator seed and the memory word views
 */
`default_nettype none

package serdes_pkg;

	localparam int symbol_width = 10;
	localparam int slot_count = 16;
	localparam int slot_width = 4;
	localparam int payload_slot = 12;

	localparam int ram_depth = 2048;
	localparam int addr_width = 11;
	localparam int word_width = 16;

	localparam int prbs_width = 32;
	localparam logic [prbs_width-1:0] prbs_seed = 32'h1d87_c0a5; // any nonzero value

	localparam logic [symbol_width-1:0] idle_symbol = '1;
	localparam logic [symbol_width-1:0] alt_symbol = 10'b01_0101_0101;

	// loader states
	localparam logic [1:0] load_idle = 2'd0;
	localparam logic [1:0] load_fill = 2'd1;
	localparam logic [1:0] load_done = 2'd2;

	typedef union packed {
		logic [word_width-1:0] raw; // as written by the loader
		struct packed {
			logic [word_width-symbol_width-1:0] spare;
			logic [symbol_width-1:0] symbol; // payload slot symbol
		} field;
	} ram_word_t;

endpackage

`default_nettype wire

//--- prbs_gen.sv
/*
 * pseudo-random generator for the pattern memory
 * 32-bit fibonacci lfsr, taps 31 21 1 0, steps only when asked
 */
`timescale 1ns/1ps
`default_nettype none

module prbs_gen import serdes_pkg::*; (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    prbs_step,
	input  wire                    prbs_restart,
	output logic [prbs_width-1:0]  prbs_word
);

	logic feedback;

	assign feedback = prbs_word[prbs_width-1] ^ prbs_word[21]
		^ prbs_word[1] ^ prbs_word[0];

	always_ff @(posedge clock) begin
		if (reset || prbs_restart) begin
			prbs_word <= prbs_seed; // rewind
		end else if (prbs_step) begin
			prbs_word <= {prbs_word[prbs_width-2:0], feedback};
		end
	end

endmodule

`default_nettype wire

//--- pattern_ram.sv
/*
 * pattern memory, 2048 x 16
 * one write port, one read port with registered output
 */
`timescale 1ns/1ps
`default_nettype none

module pattern_ram import serdes_pkg::*; (
	input  wire                    clock,
	input  wire                    write_enable,
	input  wire [addr_width-1:0]   write_address,
	input  wire ram_word_t         write_data,
	input  wire [addr_width-1:0]   read_address,
	output ram_word_t              read_data
);

	ram_word_t mem [ram_depth];

	always_ff @(posedge clock) begin
		if (write_enable) begin
			mem[write_address] <= write_data;
		end
	end

	always_ff @(posedge clock) begin
		read_data <= mem[read_address]; // one cycle latency
	end

endmodule

`default_nettype wire

//--- ram_loader.sv
/*
 * pattern memory loader
 * fills every address with generator words on a four-phase req/ack handshake
 */
`timescale 1ns/1ps
`default_nettype none

module ram_loader import serdes_pkg::*; (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    load_req,
	output logic                   load_ack,
	output logic                   loaded,
	input  wire [prbs_width-1:0]   prbs_word,
	output logic                   prbs_step,
	output logic                   prbs_restart,
	output logic                   write_enable,
	output logic [addr_width-1:0]  write_address,
	output ram_word_t              write_data
);

	logic [1:0] state;
	logic [addr_width-1:0] fill_address;

	assign prbs_restart = (state == load_idle) && load_req; // seed ready for first write
	assign prbs_step = (state == load_fill);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= load_idle;
			fill_address <= '0;
			write_enable <= 1'b0;
			loaded <= 1'b0;
			load_ack <= 1'b0;
		end else begin
			write_enable <= 1'b0;
			case (state)
				load_idle: begin
					if (load_req) begin
						loaded <= 1'b0; // stops the stream
						fill_address <= '0;
						state <= load_fill;
					end
				end
				load_fill: begin
					write_enable <= 1'b1;
					fill_address <= fill_address + 1'b1;
					if (fill_address == addr_width'(ram_depth - 1)) begin
						state <= load_done;
					end
				end
				load_done: begin
					// last word leaves the write register first
					if (!load_ack && !write_enable) begin
						loaded <= 1'b1;
						load_ack <= 1'b1;
					end else if (load_ack && !load_req) begin
						load_ack <= 1'b0; // handshake complete
						state <= load_idle;
					end
				end
				default: begin
					state <= load_idle;
				end
			endcase
		end
	end

	// write port register
	always_ff @(posedge clock) begin
		write_address <= fill_address;
		write_data.raw <= prbs_word[word_width-1:0];
	end

endmodule

`default_nettype wire

//--- frame_sequencer.sv
/*
 * frame sequencer
 * sixteen-slot frame: thermometer, zero, alternating, payload, idle
 * one payload word per frame, sync on slot 0
 */
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer import serdes_pkg::*; (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      loaded,
	output logic [addr_width-1:0]    read_address,
	input  wire ram_word_t           read_data,
	output logic [symbol_width-1:0]  data_bus,
	output logic                     sync
);

	logic [slot_width-1:0] slot;
	logic [addr_width-1:0] frame;
	logic [symbol_width-1:0] next_symbol;
	logic last_slot;

	assign last_slot = (slot == slot_width'(slot_count - 1));

	// address is valid from slot 0, data long before the payload slot
	assign read_address = frame;

	always_ff @(posedge clock) begin
		if (reset || !loaded) begin
			slot <= '0;
			frame <= '0;
		end else begin
			slot <= slot + 1'b1; // wraps at slot_count
			if (last_slot) begin
				frame <= frame + 1'b1; // wraps at ram_depth
			end
		end
	end

	always_comb begin
		if (slot < slot_width'(symbol_width)) begin
			next_symbol = idle_symbol >> slot; // thermometer
		end else if (slot == slot_width'(symbol_width)) begin
			next_symbol = '0;
		end else if (slot == slot_width'(symbol_width + 1)) begin
			next_symbol = alt_symbol;
		end else if (slot == slot_width'(payload_slot)) begin
			next_symbol = read_data.field.symbol;
		end else begin
			next_symbol = idle_symbol;
		end
	end

	// output stage
	always_ff @(posedge clock) begin
		if (reset || !loaded) begin
			data_bus <= idle_symbol;
			sync <= 1'b0;
		end else begin
			data_bus <= next_symbol;
			sync <= (slot == '0); // marks frame start
		end
	end

endmodule

`default_nettype wire

//--- serializer_top.sv
/*
 * serializer test pattern source
 * loader, generator, pattern memory and frame sequencer on one clock
 */
`timescale 1ns/1ps
`default_nettype none

module serializer_top import serdes_pkg::*; (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      load_req,
	output wire                      load_ack,
	output wire                      loaded,
	output wire [symbol_width-1:0]   data_bus,
	output wire                      sync
);

	logic prbs_step;
	logic prbs_restart;
	logic [prbs_width-1:0] prbs_word;
	logic write_enable;
	logic [addr_width-1:0] write_address;
	ram_word_t write_data;
	logic [addr_width-1:0] read_address;
	ram_word_t read_data;

	prbs_gen prbs_i (
		.clock        (clock),
		.reset        (reset),
		.prbs_step    (prbs_step),
		.prbs_restart (prbs_restart),
		.prbs_word    (prbs_word)
	);

	ram_loader loader_i (
		.clock         (clock),
		.reset         (reset),
		.load_req      (load_req),
		.load_ack      (load_ack),
		.loaded        (loaded),
		.prbs_word     (prbs_word),
		.prbs_step     (prbs_step),
		.prbs_restart  (prbs_restart),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data)
	);

	pattern_ram ram_i (
		.clock         (clock),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data),
		.read_address  (read_address),
		.read_data     (read_data)
	);

	frame_sequencer sequencer_i (
		.clock        (clock),
		.reset        (reset),
		.loaded       (loaded),
		.read_address (read_address),
		.read_data    (read_data),
		.data_bus     (data_bus),
		.sync         (sync)
	);

endmodule

`default_nettype wire

//--- serializer_tb.sv
/*
 * serializer_top testbench
 * directed tests of the load handshake, frame layout, payload stream and reload
 */
`timescale 1ns/1ps
`default_nettype none

module serializer_tb import serdes_pkg::*; ();

	localparam int clock_half = 50;
	localparam int drive_delay = 5;
	localparam int reset_cycles = 4;
	localparam int load_cycles = ram_depth + 2; // request edge to load_ack
	localparam int fixed_frames = 3;
	localparam int payload_frames = 41;
	// two loads and about ninety frames need under 6000 cycles
	localparam int timeout_cycles = 20000;

	logic clock = 1'b0;
	logic reset;
	logic load_req;
	wire load_ack;
	wire loaded;
	wire [symbol_width-1:0] data_bus;
	wire sync;

	int unsigned cycle_count = 0;
	int unsigned lcg_state = 41;

	serializer_top dut_i (
		.clock    (clock),
		.reset    (reset),
		.load_req (load_req),
		.load_ack (load_ack),
		.loaded   (loaded),
		.data_bus (data_bus),
		.sync     (sync)
	);

	always #clock_half clock = ~clock;

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count == timeout_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("STATUS: FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// one step of the reference generator
	function automatic logic [prbs_width-1:0] lfsr_step(input logic [prbs_width-1:0] r);
		logic new_bit;
		new_bit = r[31] ^ r[21] ^ r[1] ^ r[0];
		return {r[prbs_width-2:0], new_bit};
	endfunction

	// payload of frame k
	function automatic logic [symbol_width-1:0] model_symbol(input int k);
		logic [prbs_width-1:0] r;
		r = prbs_seed;
		for (int i = 0; i < k; i++) begin
			r = lfsr_step(r);
		end
		return r[symbol_width-1:0];
	endfunction

	function automatic logic [symbol_width-1:0] slot_symbol(input int s,
		input logic [symbol_width-1:0] payload);
		logic [symbol_width-1:0] t;
		t = '0;
		if (s < 10) begin
			for (int i = 0; i < symbol_width - s; i++) begin
				t[i] = 1'b1; // ones in the low 10 - s bits
			end
		end else if (s == 10) begin
			t = '0;
		end else if (s == 11) begin
			t = alt_symbol;
		end else if (s == payload_slot) begin
			t = payload;
		end else begin
			t = idle_symbol;
		end
		return t;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("error at %0t ns: %s: got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic fail_plain(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "stopping on a protocol failure");
	endtask

	// drive and sample point
	task automatic next_cycle();
		@(posedge clock);
		#drive_delay;
	endtask

	task automatic wait_for_sync();
		int waited;
		waited = 0;
		while (!sync) begin
			next_cycle();
			waited++;
			if (waited > 2 * slot_count) begin
				fail_plain("no sync pulse appeared after the load finished");
			end
		end
	endtask

	// starts at the sync cycle, ends at the next one
	task automatic check_frame(input int frame, input logic [symbol_width-1:0] payload);
		for (int s = 0; s < slot_count; s++) begin
			check_value(32'(sync), 32'(s == 0),
				$sformatf("sync in frame %0d slot %0d", frame, s));
			check_value(32'(data_bus), 32'(slot_symbol(s, payload)),
				$sformatf("data_bus in frame %0d slot %0d", frame, s));
			next_cycle();
		end
	endtask

	task automatic run_load(input string tag);
		int cycles;
		cycles = 0;
		load_req = 1'b1;
		next_cycle(); // request seen here
		check_value(32'(loaded), 32'(1'b0), $sformatf("%s: loaded after request", tag));
		while (!load_ack) begin
			next_cycle();
			cycles++;
			check_value(32'(loaded), 32'(cycles == load_cycles),
				$sformatf("%s: loaded during fill", tag));
			check_value(32'(sync), 32'(1'b0), $sformatf("%s: sync during fill", tag));
			check_value(32'(data_bus), 32'(idle_symbol),
				$sformatf("%s: data_bus during fill", tag));
			if (cycles > load_cycles + 20) begin
				fail_plain("load_ack did not rise after the load request");
			end
		end
		check_value(32'(cycles), 32'(load_cycles),
			$sformatf("%s: cycles from request to load_ack", tag));
		load_req = 1'b0;
		next_cycle();
		check_value(32'(load_ack), 32'(1'b0), $sformatf("%s: load_ack after release", tag));
		check_value(32'(loaded), 32'(1'b1), $sformatf("%s: loaded after release", tag));
	endtask

	task automatic test_idle_after_reset();
		for (int i = 0; i < 20; i++) begin
			check_value(32'(load_ack), 32'(1'b0), "load_ack after reset");
			check_value(32'(loaded), 32'(1'b0), "loaded after reset");
			check_value(32'(sync), 32'(1'b0), "sync after reset");
			check_value(32'(data_bus), 32'(idle_symbol), "data_bus after reset");
			next_cycle();
		end
	endtask

	task automatic test_load_handshake();
		run_load("first load");
	endtask

	task automatic test_fixed_slots();
		wait_for_sync();
		for (int f = 0; f < fixed_frames; f++) begin
			check_frame(f, model_symbol(f));
		end
	endtask

	task automatic test_payload_slots(input int first);
		for (int f = first; f < payload_frames; f++) begin
			check_frame(f, model_symbol(f));
		end
	endtask

	task automatic test_reload();
		int unsigned gap;
		gap = lcg_next() % slot_count;
		repeat (gap) next_cycle(); // lands anywhere in a frame
		run_load("reload");
		wait_for_sync();
		test_payload_slots(0);
	endtask

	initial begin
		reset = 1'b1;
		load_req = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		#drive_delay;
		reset = 1'b0;

		test_idle_after_reset();
		test_load_handshake();
		test_fixed_slots();
		test_payload_slots(fixed_frames);
		test_reload();

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
serdes_pkg.sv
prbs_gen.sv
pattern_ram.sv
ram_loader.sv
frame_sequencer.sv
serializer_top.sv
serializer_tb.sv

//--- Makefile
# Verilator build and run of the serializer testbench

TOP = serializer_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "STATUS: PASS" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
